// File: src/heap_pkg.sv
`default_nettype none

package heap_pkg;

	// sample width and heap depth
	localparam int SAMPLE_W = 16;
	localparam int LEVELS = 4;

	// number of entries in a full heap of the given depth
	function automatic int heap_size(input int levels);
		return (1 << levels) - 1;
	endfunction

	localparam int HEAP_SIZE = heap_size(LEVELS);

	// slot index inside the widest level
	localparam int IDX_W = LEVELS - 1;

	// minimum spacing of accepted samples, in clock cycles
	localparam int SAMPLE_GAP = 4;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic [IDX_W-1:0] heap_idx_t;

	// sample on its way down, index is the slot in the receiving level
	typedef struct packed {
		logic valid;
		heap_idx_t index;
		sample_t value;
	} sift_token_t;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_drain,
		st_clear
	} heap_state_t;

endpackage

`default_nettype wire

// File: src/level_bus.sv
`default_nettype none

interface level_bus import heap_pkg::*; ();

	// read side, a pair of siblings selected by the parent node
	heap_idx_t pair_index;
	sample_t left;
	sample_t right;

	// write side, one slot written by the node of this level
	logic wr_en;
	heap_idx_t wr_index;
	sample_t wr_data;

	modport node (
		output pair_index,
		input left,
		input right,
		output wr_en,
		output wr_index,
		output wr_data
	);

	modport store (
		input pair_index,
		output left,
		output right,
		input wr_en,
		input wr_index,
		input wr_data
	);

endinterface

`default_nettype wire

// File: src/heap_counter.sv
`default_nettype none

module heap_counter #(
	parameter int CNT_W = 5
)
(
	input logic clk,
	input logic rst,
	input logic restart,
	output logic [CNT_W-1:0] count
);

	// starts saturated so the first sample is never too early
	always_ff @(posedge clk)
	begin
		if (rst)
			count <= '1;
		else if (restart)
			count <= '0;
		else if (count != '1)
			count <= count + 1'b1;
	end

endmodule

`default_nettype wire

// File: src/heap_control.sv
`default_nettype none

module heap_control import heap_pkg::*; #(
	parameter int LEVELS = 4,
	parameter int CNT_W = 5
)
(
	input logic clk,
	input logic rst,
	input logic fs,
	input logic en_rec_in,
	input logic [CNT_W-1:0] count,
	output logic sample_stb,
	output logic overrun,
	output logic busy,
	output logic restart,
	output logic clear_en,
	output heap_idx_t clear_index
);

	// two cycles per level empties the pipeline
	localparam int DRAIN_LEN = 2 * LEVELS;
	// one pair address per cycle over the widest level
	localparam int CLEAR_LEN = (heap_size(LEVELS) + 1) / 4;

	heap_state_t state;
	logic fs_q;
	logic fs_stb;
	logic gap_ok;
	logic drain_done;
	logic clear_done;

	// registered rising edge of the sample-rate level
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fs_q <= 1'b0;
			fs_stb <= 1'b0;
		end
		else
		begin
			fs_q <= fs;
			fs_stb <= fs && !fs_q;
		end
	end

	// count reads one less than the cycles since the last restart
	assign gap_ok = int'(count) >= SAMPLE_GAP - 1;
	assign drain_done = int'(count) == DRAIN_LEN - 1;
	assign clear_done = int'(count) == CLEAR_LEN - 1;

	assign sample_stb = fs_stb && (state == st_run) && gap_ok;
	assign restart = sample_stb || ((state == st_run) && !en_rec_in)
		|| ((state == st_drain) && drain_done);
	assign clear_en = state == st_clear;
	assign clear_index = heap_idx_t'(count);
	assign busy = (state == st_drain) || (state == st_clear);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= st_idle;
			overrun <= 1'b0;
		end
		else
		begin
			overrun <= fs_stb && (state == st_run) && !gap_ok;
			case (state)
				st_idle:
					if (en_rec_in)
						state <= st_run;
				st_run:
					if (!en_rec_in)
						state <= st_drain;
				st_drain:
					if (drain_done)
						state <= st_clear;
				st_clear:
					if (clear_done)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/heap_root.sv
`default_nettype none

module heap_root import heap_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic sample_stb,
	input sample_t data_in,
	input logic clear_en,
	level_bus.store bus,
	output sample_t data_out,
	output logic out_valid,
	output sample_t root,
	output sift_token_t token_out
);

	sample_t root_q;
	sample_t tok_value;
	logic tok_valid;
	logic below;

	// a sample under the current minimum leaves straight away
	assign below = data_in < root_q;

	// level 0 holds a single entry, node 0 rewrites it
	always_ff @(posedge clk)
	begin
		if (rst || clear_en)
			root_q <= '0;
		else if (bus.wr_en)
			root_q <= bus.wr_data;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			tok_valid <= 1'b0;
		end
		else
		begin
			out_valid <= sample_stb;
			tok_valid <= sample_stb && !below;
		end
	end

	always_ff @(posedge clk)
	begin
		if (sample_stb)
		begin
			data_out <= below ? data_in : root_q;
			tok_value <= data_in;
		end
	end

	assign token_out = '{valid: tok_valid, index: '0, value: tok_value};
	assign root = root_q;
	assign bus.left = root_q;
	assign bus.right = root_q;

endmodule

`default_nettype wire

// File: src/level_ram.sv
`default_nettype none

module level_ram import heap_pkg::*; #(
	parameter int LEVEL = 1
)
(
	input logic clk,
	input logic clear_en,
	input heap_idx_t clear_index,
	level_bus.store bus
);

	localparam int PAIRS = 1 << (LEVEL - 1);
	localparam int PA_W = (LEVEL > 1) ? LEVEL - 1 : 1;

	// left and right siblings kept apart so one pair reads in a cycle
	sample_t mem_l [PAIRS] = '{default: '0};
	sample_t mem_r [PAIRS] = '{default: '0};

	logic [PA_W-1:0] rd_pair;
	logic [PA_W-1:0] wr_pair;
	logic [PA_W-1:0] clr_pair;

	assign rd_pair = bus.pair_index[PA_W-1:0];
	assign wr_pair = bus.wr_index[PA_W:1];
	assign clr_pair = clear_index[PA_W-1:0];

	assign bus.left = mem_l[rd_pair];
	assign bus.right = mem_r[rd_pair];

	// lowest index bit picks the half of the pair
	always_ff @(posedge clk)
	begin
		if (clear_en)
		begin
			mem_l[clr_pair] <= '0;
			mem_r[clr_pair] <= '0;
		end
		else if (bus.wr_en)
		begin
			if (bus.wr_index[0])
				mem_r[wr_pair] <= bus.wr_data;
			else
				mem_l[wr_pair] <= bus.wr_data;
		end
	end

endmodule

`default_nettype wire

// File: src/sift_node.sv
`default_nettype none

module sift_node import heap_pkg::*; #(
	parameter int LEVEL = 0,
	parameter int LEVELS = 4
)
(
	input logic clk,
	input logic rst,
	input sift_token_t token_in,
	level_bus.node own,
	level_bus.node child,
	output sift_token_t token_out
);

	// the bottom level has no children to compare against
	localparam bit LAST = (LEVEL == LEVELS - 1);

	sift_token_t tok_q;
	sample_t left_q;
	sample_t right_q;
	sample_t smaller;
	logic pick_right;
	logic descend;

	// first cycle: child pair addressed by the arriving token
	if (!LAST)
	begin : g_read
		assign child.pair_index = token_in.index;
	end

	always_ff @(posedge clk)
	begin
		tok_q <= token_in;
		left_q <= child.left;
		right_q <= child.right;
		if (rst)
			tok_q.valid <= 1'b0;
	end

	// second cycle: compare, place, hand on
	assign pick_right = right_q < left_q;
	assign smaller = pick_right ? right_q : left_q;
	assign descend = !LAST && (tok_q.value > smaller);

	// smaller child moves up when the value keeps sinking
	assign own.wr_en = tok_q.valid;
	assign own.wr_index = tok_q.index;
	assign own.wr_data = descend ? smaller : tok_q.value;

	always_ff @(posedge clk)
	begin
		token_out.valid <= tok_q.valid && descend;
		token_out.index <= heap_idx_t'({tok_q.index, pick_right});
		token_out.value <= tok_q.value;
		if (rst)
			token_out.valid <= 1'b0;
	end

endmodule

`default_nettype wire

// File: src/heap_filter.sv
`default_nettype none

module heap_filter import heap_pkg::*; #(
	parameter int LEVELS = heap_pkg::LEVELS
)
(
	input logic clk,
	input logic rst,
	input logic fs,
	input logic en_rec_in,
	input sample_t data_in,
	output sample_t data_out,
	output logic out_valid,
	output logic overrun,
	output logic busy
);

	// wide enough for the drain length and the clear sweep
	localparam int CNT_W = LEVELS + 1;

	logic sample_stb;
	logic restart;
	logic clear_en;
	heap_idx_t clear_index;
	logic [CNT_W-1:0] count;

	// tokens[k] enters node k, the last one falls off the bottom
	sift_token_t tokens [LEVELS + 1];

	level_bus lvl_bus [LEVELS] ();

	// level 0 has no parent node
	assign lvl_bus[0].pair_index = '0;

	heap_control #(.LEVELS(LEVELS), .CNT_W(CNT_W)) heap_control_inst (
		.clk(clk),
		.rst(rst),
		.fs(fs),
		.en_rec_in(en_rec_in),
		.count(count),
		.sample_stb(sample_stb),
		.overrun(overrun),
		.busy(busy),
		.restart(restart),
		.clear_en(clear_en),
		.clear_index(clear_index)
	);

	heap_counter #(.CNT_W(CNT_W)) heap_counter_inst (
		.clk(clk),
		.rst(rst),
		.restart(restart),
		.count(count)
	);

	heap_root heap_root_inst (
		.clk(clk),
		.rst(rst),
		.sample_stb(sample_stb),
		.data_in(data_in),
		.clear_en(clear_en),
		.bus(lvl_bus[0]),
		.data_out(data_out),
		.out_valid(out_valid),
		.root(),
		.token_out(tokens[0])
	);

	for (genvar k = 1; k < LEVELS; k++)
	begin : g_ram
		level_ram #(.LEVEL(k)) level_ram_inst (
			.clk(clk),
			.clear_en(clear_en),
			.clear_index(clear_index),
			.bus(lvl_bus[k])
		);
	end

	for (genvar k = 0; k < LEVELS; k++)
	begin : g_node
		// the bottom node never reads below itself
		localparam int CHILD = (k < LEVELS - 1) ? k + 1 : k;

		sift_node #(.LEVEL(k), .LEVELS(LEVELS)) sift_node_inst (
			.clk(clk),
			.rst(rst),
			.token_in(tokens[k]),
			.own(lvl_bus[k]),
			.child(lvl_bus[CHILD]),
			.token_out(tokens[k + 1])
		);
	end

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 4
)
(
	output logic clk
);

	// free-running clock, low at time zero
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

// File: tests/heap_filter_tb.sv
`default_nettype none

module heap_filter_tb import heap_pkg::*; ();

	localparam int NUM_RECORDS = 5;
	localparam int BUSY_LEN = 2 * LEVELS + (1 << (LEVELS - 2));
	localparam int IDLE_GAP = 5;

	logic clk;
	logic rst;
	logic fs;
	logic en_rec_in;
	sample_t data_in;
	sample_t data_out;
	logic out_valid;
	logic overrun;
	logic busy;

	logic [31:0] rng_state = 32'd98;
	int limit_cycles = 0;
	int since_accept;
	int replaced = 0;
	int passed = 0;
	int rejected = 0;
	sample_t model_heap [HEAP_SIZE];

	// stimulus is drawn before the run so the watchdog knows its length
	int rec_len [NUM_RECORDS];
	int gaps [$];
	sample_t values [$];

	tb_clock #(.PERIOD(4)) tb_clock_inst (.clk(clk));

	heap_filter heap_filter_inst (
		.clk(clk),
		.rst(rst),
		.fs(fs),
		.en_rec_in(en_rec_in),
		.data_in(data_in),
		.data_out(data_out),
		.out_valid(out_valid),
		.overrun(overrun),
		.busy(busy)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int draw(input int span);
		rng_state = xorshift(rng_state);
		return int'(rng_state % span);
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at time %0t", $time);
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp)
			stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// top-N multiset where the smallest entry gives way to a sample at least as large
	function automatic sample_t model_accept(input sample_t x);
		int low;
		sample_t out;
		low = 0;
		for (int i = 1; i < HEAP_SIZE; i++)
			if (model_heap[i] < model_heap[low])
				low = i;
		out = (x < model_heap[low]) ? x : model_heap[low];
		if (x >= model_heap[low])
		begin
			model_heap[low] = x;
			replaced++;
		end
		else
			passed++;
		return out;
	endfunction

	task automatic idle_cycles(input int n, input logic busy_exp);
		repeat (n)
		begin
			@(negedge clk);
			check_flag("out_valid", out_valid, 1'b0);
			check_flag("overrun", overrun, 1'b0);
			check_flag("busy", busy, busy_exp);
		end
	endtask

	// one fs pulse with the flags checked every cycle until the next pulse
	task automatic send_sample(input sample_t x, input int gap, input logic rec_open);
		logic accept;
		sample_t expect_out;
		accept = rec_open && since_accept >= SAMPLE_GAP;
		expect_out = '0;
		if (accept)
			expect_out = model_accept(x);
		if (rec_open && !accept)
			rejected++;
		fs = 1'b1;
		data_in = x;
		for (int i = 1; i <= gap; i++)
		begin
			@(negedge clk);
			fs = 1'b0;
			check_flag("out_valid", out_valid, accept && i == 2);
			check_flag("overrun", overrun, rec_open && !accept && i == 2);
			check_flag("busy", busy, 1'b0);
			if (accept && i == 2)
				check_sample("data_out", data_out, expect_out);
		end
		since_accept = accept ? gap : since_accept + gap;
	endtask

	task automatic run_record(input int rec);
		int busy_len;
		en_rec_in = 1'b1;
		since_accept = 1000;
		idle_cycles(2, 1'b0);
		for (int n = 0; n < rec_len[rec]; n++)
			send_sample(values.pop_front(), gaps.pop_front(), 1'b1);
		en_rec_in = 1'b0;
		busy_len = 0;
		for (int i = 0; i < BUSY_LEN + 4; i++)
		begin
			@(negedge clk);
			check_flag("out_valid", out_valid, 1'b0);
			check_flag("overrun", overrun, 1'b0);
			if (busy === 1'b1)
				busy_len++;
		end
		if (busy_len != BUSY_LEN)
			stop_run($sformatf("[ERROR] busy was high for %0d cycles instead of %0d",
				busy_len, BUSY_LEN));
		// the heap is cleared between records
		for (int i = 0; i < HEAP_SIZE; i++)
			model_heap[i] = '0;
		idle_cycles(IDLE_GAP, 1'b0);
	endtask

	initial
	begin : main
		int gap;
		int total;
		rst = 1'b1;
		fs = 1'b0;
		en_rec_in = 1'b0;
		data_in = '0;
		since_accept = 1000;
		for (int i = 0; i < HEAP_SIZE; i++)
			model_heap[i] = '0;
		total = 30;
		for (int r = 0; r < NUM_RECORDS; r++)
		begin
			rec_len[r] = 16 + draw(25);
			for (int n = 0; n < rec_len[r]; n++)
			begin
				// first two records run at the tightest legal spacing
				gap = (r < 2) ? SAMPLE_GAP : 2 + draw(8);
				gaps.push_back(gap);
				values.push_back(sample_t'(draw(65536)));
				total += gap;
			end
			total += 2 + BUSY_LEN + 4 + IDLE_GAP;
		end
		limit_cycles = 2 * total + 100;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		idle_cycles(4, 1'b0);
		// fs edges with no record open
		for (int i = 0; i < 3; i++)
			send_sample(sample_t'(draw(65536)), 5, 1'b0);
		for (int r = 0; r < NUM_RECORDS; r++)
			run_record(r);
		if (replaced == 0 || passed == 0 || rejected == 0)
			stop_run("the stimulus missed the replace, pass-through or overrun case");
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	// bounds the run once the stimulus has been drawn
	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		stop_run("watchdog expired before the test finished");
	end

endmodule

`default_nettype wire

// File: tb.f
src/heap_pkg.sv
src/level_bus.sv
src/heap_counter.sv
src/heap_control.sv
src/heap_root.sv
src/level_ram.sv
src/sift_node.sv
src/heap_filter.sv
tests/tb_clock.sv
tests/heap_filter_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= heap_filter_tb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
